// File: bench/sram_model.sv
// Behavioural 16-bit SRAM with two-cycle read latency holding the frame image
`timescale 1ns/100ps

module sram_model (
	input logic CLOCK_50_I,
	input logic [yuv_rgb_pkg::addr_w-1:0] address,
	input logic [yuv_rgb_pkg::data_w-1:0] write_data,
	input logic we_n,
	output logic [yuv_rgb_pkg::data_w-1:0] read_data
);

	logic [15:0] mem [0:yuv_rgb_pkg::rgb_offset + yuv_rgb_pkg::rgb_words - 1];  // YUV then RGB
	logic [15:0] rd_q1 = 16'h0000;                          // First read stage
	logic [15:0] rd_q2 = 16'h0000;                          // Second read stage

	always @(posedge CLOCK_50_I) begin
		if (!we_n && address < yuv_rgb_pkg::rgb_offset + yuv_rgb_pkg::rgb_words)
			mem[address] = write_data;
		if (address < yuv_rgb_pkg::rgb_offset + yuv_rgb_pkg::rgb_words) rd_q1 <= mem[address];
		else rd_q1 <= 16'h0000;                             // Unmapped words read as zero
		rd_q2 <= rd_q1;
	end

	assign read_data = rd_q2;

endmodule

// File: bench/tb_yuv_rgb.sv
// Testbench for the YUV to RGB frame converter with reference model and write checker
`timescale 1ns/100ps

module tb_yuv_rgb;

	logic CLOCK_50_I;
	logic resetn;
	logic start;
	logic [yuv_rgb_pkg::data_w-1:0] sram_read_data;
	logic [yuv_rgb_pkg::addr_w-1:0] sram_address;
	logic [yuv_rgb_pkg::data_w-1:0] sram_write_data;
	logic sram_we_n;
	logic done;

	logic [15:0] yuv_image [0:yuv_rgb_pkg::rgb_offset - 1];  // Copy of Y, U, V regions
	integer seed;
	int errors, test_errors, checks, tests, writes;
	string test_name;

	yuv_rgb_top u_yuv_rgb_top (.CLOCK_50_I, .resetn, .start, .sram_read_data, .sram_address,
		.sram_write_data, .sram_we_n, .done);

	sram_model u_sram (.CLOCK_50_I, .address(sram_address), .write_data(sram_write_data),
		.we_n(sram_we_n), .read_data(sram_read_data));

	always #4 CLOCK_50_I = ~CLOCK_50_I;                     // 8 ns period

	function automatic int frame_cycles();
		return yuv_rgb_pkg::img_height * (8 + 8 * yuv_rgb_pkg::pairs_per_row);
	endfunction

	function automatic logic [15:0] fill_word(input int a);
		logic [31:0] h;
		h = a * 32'h9e3779b1;                               // Mixes every address bit
		return h[28:13];
	endfunction

	// Chroma sample j of a row, clamped at both row ends
	function automatic int chroma(input int base, input int row, input int j);
		int jc;
		logic [15:0] w;
		jc = (j < 0) ? 0 : j;
		if (jc > yuv_rgb_pkg::pairs_per_row - 1) jc = yuv_rgb_pkg::pairs_per_row - 1;
		w = yuv_image[base + row * (yuv_rgb_pkg::img_width / 4) + jc / 2];
		return (jc % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);  // Even sample in high byte
	endfunction

	function automatic int interp(input int base, input int row, input int k);
		int s;
		s = 21 * (chroma(base, row, k - 2) + chroma(base, row, k + 3))
			- 52 * (chroma(base, row, k - 1) + chroma(base, row, k + 2))
			+ 159 * (chroma(base, row, k) + chroma(base, row, k + 1)) + 128;
		return s >>> 8;                                     // Signed, no clipping
	endfunction

	function automatic logic [7:0] clamp_byte(input int x);
		if (x < 0) return 8'd0;
		if (x > 255) return 8'd255;
		return x[7:0];
	endfunction

	function automatic logic [23:0] csc(input int y, input int u, input int v);
		int yt, r, g, b;
		yt = 76284 * (y - 16);
		r = (yt + 104595 * (v - 128)) >>> 16;
		g = (yt - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16;
		b = (yt + 132251 * (u - 128)) >>> 16;
		return {clamp_byte(r), clamp_byte(g), clamp_byte(b)};
	endfunction

	// Expected {word0, word1, word2} of one pair, which is {R0 G0 B0 R1 G1 B1}
	function automatic logic [47:0] pixel_rgb(input int pair);
		int row, k, ub, vb;
		logic [15:0] yw;
		row = pair / yuv_rgb_pkg::pairs_per_row;
		k = pair % yuv_rgb_pkg::pairs_per_row;
		ub = int'(yuv_rgb_pkg::u_offset);
		vb = int'(yuv_rgb_pkg::v_offset);
		yw = yuv_image[int'(yuv_rgb_pkg::y_offset) + pair];
		return {csc(int'(yw[15:8]), chroma(ub, row, k), chroma(vb, row, k)),
			csc(int'(yw[7:0]), interp(ub, row, k), interp(vb, row, k))};
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	// Kind 0 grey, 1 random, 2 saturating top and bottom halves
	task automatic load_image(input int kind);
		int half, row, u_off, v_off;
		logic [15:0] w;
		half = yuv_rgb_pkg::img_height / 2;
		u_off = int'(yuv_rgb_pkg::u_offset);
		v_off = int'(yuv_rgb_pkg::v_offset);
		for (int a = 0; a < int'(yuv_rgb_pkg::rgb_offset); a++) begin
			if (a < u_off) row = a / yuv_rgb_pkg::pairs_per_row;
			else if (a < v_off) row = (a - u_off) / (yuv_rgb_pkg::img_width / 4);
			else row = (a - v_off) / (yuv_rgb_pkg::img_width / 4);
			case (kind)
				0: w = 16'h8080;
				1: w = 16'($random(seed));
				default: begin
					if (a < u_off) w = (row < half) ? 16'hffff : 16'h0000;        // Y
					else if (a < v_off) w = (row < half) ? 16'h8080 : 16'h0000;   // U
					else w = (row < half) ? 16'hffff : 16'h8080;                  // V
				end
			endcase
			yuv_image[a] = w;
			u_sram.mem[a] = w;
		end
		for (int a = int'(yuv_rgb_pkg::rgb_offset);
			a < int'(yuv_rgb_pkg::rgb_offset) + yuv_rgb_pkg::rgb_words; a++) begin
			u_sram.mem[a] = fill_word(a);                   // Stale RGB words
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		writes = 0;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s finished with %0d errors", test_name, test_errors);
	endtask

	task automatic start_frame();
		@(posedge CLOCK_50_I);
		#1 start = 1'b1;
		@(posedge CLOCK_50_I);
		#1 start = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles <= 2 * frame_cycles()) begin
			@(negedge CLOCK_50_I);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("done did not rise within %0d cycles in %s", cycles, test_name);
			errors++;
			test_errors++;
		end else check_value(test_name, 16'(frame_cycles()), 16'(cycles - 1));
		repeat (3) @(negedge CLOCK_50_I);                  // Last write lands in the SRAM
		check_value(test_name, 16'(yuv_rgb_pkg::rgb_words), 16'(writes));
	endtask

	always @(negedge CLOCK_50_I) begin : compare_writes
		int idx;
		logic [47:0] exp_pair;
		if (resetn === 1'b1 && sram_we_n === 1'b0) begin
			writes++;
			idx = int'(sram_address) - int'(yuv_rgb_pkg::rgb_offset);
			if (idx < 0 || idx >= yuv_rgb_pkg::rgb_words) begin
				$display("SRAM write outside the RGB region at address %h in %s",
					sram_address, test_name);
				errors++;
				test_errors++;
			end else begin
				exp_pair = pixel_rgb(idx / 3);
				case (idx % 3)
					0: check_value(test_name, exp_pair[47:32], sram_write_data);
					1: check_value(test_name, exp_pair[31:16], sram_write_data);
					default: check_value(test_name, exp_pair[15:0], sram_write_data);
				endcase
			end
		end
	end

	initial begin : watchdog
		repeat (2 * 4 * frame_cycles() + 200) @(posedge CLOCK_50_I);  // Four frame runs
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		seed = 32'h2173;
		errors = 0;
		checks = 0;
		tests = 0;
		CLOCK_50_I = 1'b0;
		resetn = 1'b0;
		start = 1'b0;

		begin_test("reset_idle");
		repeat (8) @(posedge CLOCK_50_I);
		#1 resetn = 1'b1;
		load_image(1);                                      // Image in place once reset has settled
		repeat (20) begin
			@(negedge CLOCK_50_I);
			check_value(test_name, 16'd1, 16'(sram_we_n));
			check_value(test_name, 16'd0, 16'(done));
		end
		for (int a = 0; a < int'(yuv_rgb_pkg::rgb_offset) + yuv_rgb_pkg::rgb_words; a++) begin
			check_value(test_name,
				(a < int'(yuv_rgb_pkg::rgb_offset)) ? yuv_image[a] : fill_word(a),
				u_sram.mem[a]);
		end
		check_value(test_name, 16'd0, 16'(writes));
		end_test();

		begin_test("grey_frame");
		load_image(0);
		start_frame();
		wait_done();
		end_test();

		begin_test("random_frame");
		load_image(1);
		start_frame();
		wait_done();
		end_test();

		begin_test("saturating_frame");
		load_image(2);
		start_frame();
		wait_done();
		check_value(test_name, 16'h00ff,                    // Bright red corner saturates
			16'(u_sram.mem[yuv_rgb_pkg::rgb_offset][15:8]));
		check_value(test_name, 16'h0000,                    // Dark blue corner floors
			16'(u_sram.mem[yuv_rgb_pkg::rgb_offset + yuv_rgb_pkg::rgb_words - 1][7:0]));
		end_test();

		begin_test("restart");
		repeat (10) begin
			@(negedge CLOCK_50_I);
			check_value(test_name, 16'd1, 16'(done));       // Level held until next start
		end
		load_image(1);
		start_frame();
		check_value(test_name, 16'd0, 16'(done));
		wait_done();
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) $display(">>> PASS");
		else $display(">>> FAIL");
		$finish;
	end

endmodule

// File: bench/yuv_rgb_chk.sv
// Bound checks on SRAM write region, done level and idle write enable of the converter
`timescale 1ns/100ps

module yuv_rgb_chk (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	input logic done,
	input logic sram_we_n,
	input logic [yuv_rgb_pkg::addr_w-1:0] sram_address,
	input yuv_rgb_pkg::fsm_state_t state
);

	wr_region: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!sram_we_n |-> sram_address >= yuv_rgb_pkg::rgb_offset)
		else $error("SRAM write below the RGB region at address %h", sram_address);

	done_hold: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		$fell(done) |-> $past(start))
		else $error("done fell without a start pulse");

	// Last write of a frame is still registered on the first idle cycle
	idle_we: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(state == yuv_rgb_pkg::idle && $past(state) == yuv_rgb_pkg::idle) |-> sram_we_n)
		else $error("SRAM write enable active while idle");

endmodule

bind yuv_rgb_top yuv_rgb_chk u_chk (.CLOCK_50_I, .resetn, .start, .done, .sram_we_n,
	.sram_address, .state(u_fsm.state));

// File: design/chroma_upsampler.sv
// Chroma upsampler: six-tap window and 21/-52/159 interpolation for one plane
`timescale 1ns/100ps

module chroma_upsampler (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic [yuv_rgb_pkg::data_w-1:0] sram_read_data,
	input logic load_word,
	input logic filt_step,
	input logic row_start,
	input logic last_pair,
	output logic [yuv_rgb_pkg::pix_w-1:0] c_even,
	output logic signed [yuv_rgb_pkg::pix_w+1:0] c_odd
);

	logic [yuv_rgb_pkg::pix_w-1:0] sr [6];                  // c[k-2] .. c[k+3]
	logic [yuv_rgb_pkg::data_w-1:0] q;                      // Word waiting to be shifted in
	logic [1:0] q_cnt;                                      // Samples left in q
	logic [1:0] fill;                                       // 2 once the row window is primed
	logic [1:0] step;
	logic filt_q;
	logic shift;
	logic [yuv_rgb_pkg::pix_w-1:0] next_smp;
	logic [8:0] s05, s14, s23;
	logic [19:0] p21, p52, p159;
	logic signed [19:0] acc, sum_f;

	assign shift = filt_q && !filt_step && !last_pair;      // Slide after the filter
	assign next_smp = load_word ? sram_read_data[15:8] :
		(q_cnt == 2'd2) ? q[15:8] : (q_cnt == 2'd1) ? q[7:0] : sr[5];   // Repeat at right edge

	assign s05 = 9'(sr[0]) + 9'(sr[5]);
	assign s14 = 9'(sr[1]) + 9'(sr[4]);
	assign s23 = 9'(sr[2]) + 9'(sr[3]);
	assign p21 = 20'(yuv_rgb_pkg::flt_d21) * 20'(s05);
	assign p52 = 20'(yuv_rgb_pkg::flt_d52) * 20'(s14);
	assign p159 = 20'(yuv_rgb_pkg::flt_d159) * 20'(s23);
	assign sum_f = acc + $signed(p159) + 20'sd128;          // Rounding before the shift

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			fill <= 2'd0;
			q_cnt <= 2'd0;
			step <= 2'd0;
			filt_q <= 1'b0;
		end else begin
			filt_q <= filt_step;
			step <= filt_step ? step + 2'd1 : 2'd0;
			if (row_start) begin
				fill <= 2'd0;
				q_cnt <= 2'd0;
			end else if (load_word && fill != 2'd2) fill <= fill + 2'd1;
			else if (load_word) q_cnt <= shift ? 2'd1 : 2'd2;
			else if (shift && q_cnt != 2'd0) q_cnt <= q_cnt - 2'd1;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (load_word && fill == 2'd0 && !row_start) begin
			sr[0] <= sram_read_data[15:8];                  // Left edge clamps to c0
			sr[1] <= sram_read_data[15:8];
			sr[2] <= sram_read_data[15:8];
			sr[3] <= sram_read_data[7:0];
		end else if (load_word && fill == 2'd1 && !row_start) begin
			sr[4] <= sram_read_data[15:8];
			sr[5] <= sram_read_data[7:0];
		end else begin
			if (load_word) q <= sram_read_data;
			if (shift) sr <= '{sr[1], sr[2], sr[3], sr[4], sr[5], next_smp};
		end
		if (filt_step) begin
			case (step)
				2'd0: acc <= $signed(p21);
				2'd1: acc <= acc - $signed(p52);
				default: begin
					c_odd <= 10'(sum_f >>> 8);
					c_even <= sr[2];                        // Held through the CSC steps
				end
			endcase
		end
	end

endmodule

// File: design/frame_counter.sv
// Pair and row position within the frame, decoded into row and frame end flags
`timescale 1ns/100ps

module frame_counter (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic pair_inc,
	input logic row_start,
	output logic last_pair,
	output logic pair_even,
	output logic last_row
);

	logic [yuv_rgb_pkg::pair_cnt_w-1:0] pair_cnt;
	logic [yuv_rgb_pkg::row_cnt_w-1:0] row_cnt;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			pair_cnt <= '0;
			row_cnt <= '0;
		end else if (row_start) begin
			pair_cnt <= '0;                                 // New row
		end else if (pair_inc) begin
			pair_cnt <= pair_cnt + 1'b1;
			if (last_pair) row_cnt <= last_row ? '0 : row_cnt + 1'b1;   // Wraps for next frame
		end
	end

	assign last_pair = (pair_cnt == yuv_rgb_pkg::pair_cnt_w'(yuv_rgb_pkg::pairs_per_row - 1));
	assign last_row = (row_cnt == yuv_rgb_pkg::row_cnt_w'(yuv_rgb_pkg::img_height - 1));
	// New chroma word only while one is left in the row
	assign pair_even = !pair_cnt[0] && (int'(pair_cnt) < yuv_rgb_pkg::pairs_per_row - 4);

endmodule

// File: design/pixel_pair_fsm.sv
// Frame sequencer stepping the row lead-in and the 8-cycle pixel pair slot
`timescale 1ns/100ps

module pixel_pair_fsm (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	input logic last_pair,
	input logic pair_even,
	input logic last_row,
	output logic done,
	output logic rd_y,
	output logic rd_u,
	output logic rd_v,
	output logic load_u_word,
	output logic load_v_word,
	output logic filt_step,
	output logic y_load,
	output logic csc_step,
	output logic wr_en,
	output logic [1:0] wr_word,
	output logic pair_inc,
	output logic row_start
);

	yuv_rgb_pkg::fsm_state_t state;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= yuv_rgb_pkg::idle;
			done <= 1'b0;
		end else begin
			case (state)
				yuv_rgb_pkg::idle: begin
					if (start) begin
						state <= yuv_rgb_pkg::lead_in_0;
						done <= 1'b0;                       // Cleared only by a new frame
					end
				end
				yuv_rgb_pkg::lead_in_7: state <= yuv_rgb_pkg::pair_0;
				yuv_rgb_pkg::pair_7: begin
					if (!last_pair) state <= yuv_rgb_pkg::pair_0;
					else if (!last_row) state <= yuv_rgb_pkg::lead_in_0;   // Next row
					else begin
						state <= yuv_rgb_pkg::idle;         // Frame finished
						done <= 1'b1;
					end
				end
				default: state <= yuv_rgb_pkg::fsm_state_t'(state + 5'd1);
			endcase
		end
	end

	// Strobes decoded straight from the state, read data lands three cycles on
	always_comb begin
		rd_y = 1'b0;
		rd_u = 1'b0;
		rd_v = 1'b0;
		load_u_word = 1'b0;
		load_v_word = 1'b0;
		filt_step = 1'b0;
		y_load = 1'b0;
		csc_step = 1'b0;
		wr_en = 1'b0;
		wr_word = 2'd0;
		pair_inc = 1'b0;
		row_start = 1'b0;
		case (state)
			yuv_rgb_pkg::lead_in_0: begin
				row_start = 1'b1;                           // Restart pair count and chroma fill
				rd_u = 1'b1;                                // U word 0
			end
			yuv_rgb_pkg::lead_in_1: rd_v = 1'b1;            // V word 0
			yuv_rgb_pkg::lead_in_2: rd_u = 1'b1;            // U word 1
			yuv_rgb_pkg::lead_in_3: begin
				rd_v = 1'b1;                                // V word 1
				load_u_word = 1'b1;
			end
			yuv_rgb_pkg::lead_in_4: begin
				rd_y = 1'b1;                                // Y of pair 0
				load_v_word = 1'b1;
			end
			yuv_rgb_pkg::lead_in_5: load_u_word = 1'b1;
			yuv_rgb_pkg::lead_in_6: load_v_word = 1'b1;
			yuv_rgb_pkg::lead_in_7: y_load = 1'b1;
			yuv_rgb_pkg::pair_0: rd_u = pair_even;          // Chroma two pairs ahead
			yuv_rgb_pkg::pair_1: begin
				rd_v = pair_even;
				filt_step = 1'b1;                           // Outer taps
			end
			yuv_rgb_pkg::pair_2: filt_step = 1'b1;          // Middle taps
			yuv_rgb_pkg::pair_3: begin
				filt_step = 1'b1;                           // Centre taps and round
				rd_y = !last_pair;                          // Y of the next pair
				load_u_word = pair_even;
			end
			yuv_rgb_pkg::pair_4: begin
				load_v_word = pair_even;
				csc_step = 1'b1;                            // Even pixel
			end
			yuv_rgb_pkg::pair_5: begin
				csc_step = 1'b1;                            // Odd pixel
				wr_en = 1'b1;
				wr_word = 2'd0;
			end
			yuv_rgb_pkg::pair_6: begin
				y_load = !last_pair;
				wr_en = 1'b1;
				wr_word = 2'd1;
			end
			yuv_rgb_pkg::pair_7: begin
				wr_en = 1'b1;
				wr_word = 2'd2;
				pair_inc = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: design/rgb_converter.sv
// Colour-space conversion of one pixel pair with clipping and packing into three SRAM words
`timescale 1ns/100ps

module rgb_converter (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic [yuv_rgb_pkg::data_w-1:0] sram_read_data,
	input logic y_load,
	input logic csc_step,
	input logic [yuv_rgb_pkg::pix_w-1:0] u_even,
	input logic signed [yuv_rgb_pkg::pix_w+1:0] u_odd,
	input logic [yuv_rgb_pkg::pix_w-1:0] v_even,
	input logic signed [yuv_rgb_pkg::pix_w+1:0] v_odd,
	output logic [yuv_rgb_pkg::data_w-1:0] word0,
	output logic [yuv_rgb_pkg::data_w-1:0] word1,
	output logic [yuv_rgb_pkg::data_w-1:0] word2
);

	logic [yuv_rgb_pkg::data_w-1:0] y_pair;                 // Even pixel in high byte
	logic odd_px;                                           // Second csc_step cycle
	logic signed [31:0] op_y, op_u, op_v;
	logic signed [31:0] y_term, r_sum, g_sum, b_sum;
	logic [7:0] r0, g0, b0, r1, g1, b1;

	function automatic logic [7:0] clip(input logic signed [31:0] x);
		if (x < 0) return 8'd0;
		else if (x > 32'sd255) return 8'd255;
		else return x[7:0];
	endfunction

	always_comb begin
		if (odd_px) begin
			op_y = $signed({24'd0, y_pair[7:0]});
			op_u = $signed({{22{u_odd[9]}}, u_odd});        // Interpolated, may be out of range
			op_v = $signed({{22{v_odd[9]}}, v_odd});
		end else begin
			op_y = $signed({24'd0, y_pair[15:8]});
			op_u = $signed({24'd0, u_even});
			op_v = $signed({24'd0, v_even});
		end
		op_y = op_y - yuv_rgb_pkg::y_bias;
		op_u = op_u - yuv_rgb_pkg::c_bias;
		op_v = op_v - yuv_rgb_pkg::c_bias;
		y_term = $signed({14'd0, yuv_rgb_pkg::csc_y}) * op_y;
		r_sum = (y_term + $signed({14'd0, yuv_rgb_pkg::csc_rv}) * op_v) >>> 16;
		g_sum = (y_term - $signed({14'd0, yuv_rgb_pkg::csc_gu}) * op_u
			- $signed({14'd0, yuv_rgb_pkg::csc_gv}) * op_v) >>> 16;
		b_sum = (y_term + $signed({14'd0, yuv_rgb_pkg::csc_bu}) * op_u) >>> 16;
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) odd_px <= 1'b0;
		else odd_px <= csc_step && !odd_px;                 // Even then odd pixel
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (y_load) y_pair <= sram_read_data;               // Next pair, current one is done
		if (csc_step && !odd_px) begin
			r0 <= clip(r_sum);
			g0 <= clip(g_sum);
			b0 <= clip(b_sum);
		end
		if (csc_step && odd_px) begin
			r1 <= clip(r_sum);
			g1 <= clip(g_sum);
			b1 <= clip(b_sum);
		end
	end

	assign word0 = {r0, g0};
	assign word1 = {b0, r1};
	assign word2 = {g1, b1};

endmodule

// File: design/sram_port.sv
// SRAM address generation for the Y, U, V and RGB regions with registered write port
`timescale 1ns/100ps

module sram_port (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic rd_y,
	input logic rd_u,
	input logic rd_v,
	input logic wr_en,
	input logic [1:0] wr_word,
	input logic row_start,
	input logic [yuv_rgb_pkg::data_w-1:0] word0,
	input logic [yuv_rgb_pkg::data_w-1:0] word1,
	input logic [yuv_rgb_pkg::data_w-1:0] word2,
	output logic [yuv_rgb_pkg::addr_w-1:0] sram_address,
	output logic [yuv_rgb_pkg::data_w-1:0] sram_write_data,
	output logic sram_we_n
);

	logic [yuv_rgb_pkg::addr_w-1:0] y_cnt, u_cnt, v_cnt, rgb_cnt;
	logic [yuv_rgb_pkg::addr_w-1:0] y_idx, u_idx, v_idx;
	logic frame_clr;
	logic rgb_wrap;

	assign frame_clr = row_start && (rgb_cnt == '0);        // First row, nothing written yet
	assign rgb_wrap = (rgb_cnt == yuv_rgb_pkg::addr_w'(yuv_rgb_pkg::rgb_words - 1));
	assign y_idx = frame_clr ? '0 : y_cnt;
	assign u_idx = frame_clr ? '0 : u_cnt;
	assign v_idx = frame_clr ? '0 : v_cnt;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			y_cnt <= '0;
			u_cnt <= '0;
			v_cnt <= '0;
			rgb_cnt <= '0;
			sram_address <= '0;
			sram_we_n <= 1'b1;
		end else begin
			sram_we_n <= !wr_en;
			y_cnt <= rd_y ? y_idx + 1'b1 : y_idx;
			u_cnt <= rd_u ? u_idx + 1'b1 : u_idx;
			v_cnt <= rd_v ? v_idx + 1'b1 : v_idx;
			if (wr_en) begin
				sram_address <= yuv_rgb_pkg::rgb_offset + rgb_cnt;
				rgb_cnt <= rgb_wrap ? '0 : rgb_cnt + 1'b1;  // Back to word 0 for next frame
			end
			else if (rd_y) sram_address <= yuv_rgb_pkg::y_offset + y_idx;
			else if (rd_u) sram_address <= yuv_rgb_pkg::u_offset + u_idx;
			else if (rd_v) sram_address <= yuv_rgb_pkg::v_offset + v_idx;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (wr_en) begin
			case (wr_word)
				2'd0: sram_write_data <= word0;             // R0 G0
				2'd1: sram_write_data <= word1;             // B0 R1
				default: sram_write_data <= word2;          // G1 B1
			endcase
		end
	end

endmodule

// File: design/yuv_rgb_pkg.sv
// YUV to RGB frame converter package with geometry, SRAM regions, coefficients and FSM states
package yuv_rgb_pkg;

	localparam int img_width = 16;                              // Pixels per row, multiple of 4
	localparam int img_height = 4;                              // Rows per frame
	localparam int pairs_per_row = img_width / 2;
	localparam int frame_pairs = pairs_per_row * img_height;
	localparam int rgb_words = 3 * frame_pairs;                 // Three packed words per pair
	localparam int pair_cnt_w = $clog2(pairs_per_row);
	localparam int row_cnt_w = (img_height > 1) ? $clog2(img_height) : 1;

	localparam int addr_w = 18;                                 // SRAM address width
	localparam int data_w = 16;                                 // SRAM word width
	localparam int pix_w = 8;                                   // One sample

	localparam logic [addr_w-1:0] y_offset = '0;
	localparam logic [addr_w-1:0] u_offset = addr_w'(img_width * img_height / 2);
	localparam logic [addr_w-1:0] v_offset = u_offset + addr_w'(img_width * img_height / 4);
	localparam logic [addr_w-1:0] rgb_offset = v_offset + addr_w'(img_width * img_height / 4);

	localparam logic [7:0] flt_d21 = 8'd21;                     // Outer taps
	localparam logic [7:0] flt_d52 = 8'd52;                     // Middle taps, subtracted
	localparam logic [7:0] flt_d159 = 8'd159;                   // Centre taps

	localparam logic [17:0] csc_y = 18'd76284;
	localparam logic [17:0] csc_rv = 18'd104595;
	localparam logic [17:0] csc_gu = 18'd25624;
	localparam logic [17:0] csc_gv = 18'd53281;
	localparam logic [17:0] csc_bu = 18'd132251;

	localparam int y_bias = 16;
	localparam int c_bias = 128;

	// Lead-in primes one row, pair states repeat once per pixel pair
	typedef enum logic [4:0] {
		idle,
		lead_in_0, lead_in_1, lead_in_2, lead_in_3, lead_in_4, lead_in_5, lead_in_6, lead_in_7,
		pair_0, pair_1, pair_2, pair_3, pair_4, pair_5, pair_6, pair_7
	} fsm_state_t;

endpackage

// File: design/yuv_rgb_top.sv
// YUV 4:2:2 to packed RGB frame converter over a shared 16-bit SRAM
`timescale 1ns/100ps

module yuv_rgb_top (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	input logic [yuv_rgb_pkg::data_w-1:0] sram_read_data,
	output logic [yuv_rgb_pkg::addr_w-1:0] sram_address,
	output logic [yuv_rgb_pkg::data_w-1:0] sram_write_data,
	output logic sram_we_n,
	output logic done
);

	logic rd_y, rd_u, rd_v, load_u_word, load_v_word, filt_step, y_load, csc_step;
	logic wr_en, pair_inc, row_start, last_pair, pair_even, last_row;
	logic [1:0] wr_word;
	logic [yuv_rgb_pkg::pix_w-1:0] u_even, v_even;
	logic signed [yuv_rgb_pkg::pix_w+1:0] u_odd, v_odd;
	logic [yuv_rgb_pkg::data_w-1:0] word0, word1, word2;

	pixel_pair_fsm u_fsm (.CLOCK_50_I, .resetn, .start, .last_pair, .pair_even, .last_row,
		.done, .rd_y, .rd_u, .rd_v, .load_u_word, .load_v_word, .filt_step, .y_load,
		.csc_step, .wr_en, .wr_word, .pair_inc, .row_start);

	frame_counter u_cnt (.CLOCK_50_I, .resetn, .pair_inc, .row_start, .last_pair,
		.pair_even, .last_row);

	chroma_upsampler u_up_u (.CLOCK_50_I, .resetn, .sram_read_data, .load_word(load_u_word),
		.filt_step, .row_start, .last_pair, .c_even(u_even), .c_odd(u_odd));

	chroma_upsampler u_up_v (.CLOCK_50_I, .resetn, .sram_read_data, .load_word(load_v_word),
		.filt_step, .row_start, .last_pair, .c_even(v_even), .c_odd(v_odd));

	rgb_converter u_csc (.CLOCK_50_I, .resetn, .sram_read_data, .y_load, .csc_step,
		.u_even, .u_odd, .v_even, .v_odd, .word0, .word1, .word2);

	sram_port u_port (.CLOCK_50_I, .resetn, .rd_y, .rd_u, .rd_v, .wr_en, .wr_word,
		.row_start, .word0, .word1, .word2, .sram_address, .sram_write_data, .sram_we_n);

endmodule

// File: flist.f
design/yuv_rgb_pkg.sv
design/pixel_pair_fsm.sv
design/frame_counter.sv
design/chroma_upsampler.sv
design/rgb_converter.sv
design/sram_port.sv
design/yuv_rgb_top.sv
bench/sram_model.sv
bench/yuv_rgb_chk.sv
bench/tb_yuv_rgb.sv

// File: run.sh
#!/bin/sh
# Build and run the YUV to RGB converter simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_yuv_rgb \
	-f flist.f --Mdir obj_dir -o sim_yuv_rgb; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_yuv_rgb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
exit 0
